/* rtl/params_pkg.sv */
// widths, forwarding and kind codes, instruction, retire, redirect, memory and hazard structs
package params_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int TAG_W      = 8;
  localparam int IMM_W      = 12;

  // ==========================================================
  // encodings
  // ==========================================================
  typedef enum logic [2:0] {
    NO_FORWARD_SEL         = 3'd0,
    FORWARD_SEL_MEM_RESULT = 3'd1,
    FORWARD_SEL_WB_RESULT  = 3'd2
  } fwd_sel_t;

  typedef enum logic [1:0] {
    KIND_ALU    = 2'd0,
    KIND_LOAD   = 2'd1,
    KIND_BRANCH = 2'd2,
    KIND_JUMP   = 2'd3
  } inst_kind_t;

  // ==========================================================
  // pre-decoded instruction and pipeline outputs
  // ==========================================================
  typedef struct packed {
    logic                  valid;
    logic [TAG_W-1:0]      tag;
    inst_kind_t            kind;
    logic                  use_imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
    logic                  predict_taken;
    logic                  actual_taken;
    logic                  trap;
    // branch/jump target, or handler tag when trap is set
    logic [TAG_W-1:0]      target;
  } inst_t;

  typedef struct packed {
    logic                  valid;
    logic [TAG_W-1:0]      tag;
    logic                  trap;
    logic                  writes_rd;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
  } retire_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } mem_rsp_t;

  // ==========================================================
  // hazard unit interface
  // ==========================================================
  typedef struct packed {
    logic     if_id_stall;
    logic     id_ex_stall;
    logic     ex_mem_stall;
    logic     mem_wb_stall;
    logic     if_id_flush;
    logic     id_ex_flush;
    logic     ex_mem_flush;
    logic     mem_wb_flush;
    logic     id_fwd_a;
    logic     id_fwd_b;
    fwd_sel_t ex_fwd_a;
    fwd_sel_t ex_fwd_b;
  } hazard_ctrl_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [REG_ADDR_W-1:0] ex_rs1;
    logic [REG_ADDR_W-1:0] ex_rs2;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  mem_rd_write;
    logic                  wb_rd_write;
    logic                  ex_mem_read;
    logic                  mem_is_branch;
    logic                  mem_jump_taken;
    logic                  mem_mispredict;
    logic                  id_predict_taken;
    logic                  ex_trap;
    logic                  mem_trap;
    logic                  wb_trap;
  } stage_info_t;

endpackage

/* rtl/hazard_unit.sv */
// hazard unit: operand forwarding select, load-use and memory stalls, per-register flushes
`timescale 1ns/1ps

module hazard_unit (
  input  params_pkg::stage_info_t  stage_i,
  input  logic                     mem_req_i,
  input  logic                     mem_done_i,
  output params_pkg::hazard_ctrl_t ctrl_o
);
  import params_pkg::*;

  logic     id_wb_rs1_match;
  logic     id_wb_rs2_match;
  logic     id_ex_rs1_match;
  logic     id_ex_rs2_match;
  logic     ex_mem_rs1_match;
  logic     ex_mem_rs2_match;
  logic     ex_wb_rs1_match;
  logic     ex_wb_rs2_match;
  logic     load_use_stall;
  logic     mem_req_stall;
  logic     jump_flush;
  logic     mispredict_flush;
  logic     any_trap;
  logic     if_id_stall;
  logic     id_ex_stall;
  logic     ex_mem_stall;
  logic     mem_wb_stall;
  fwd_sel_t ex_fwd_a;
  fwd_sel_t ex_fwd_b;

  // register matches, x0 never matches
  assign id_wb_rs1_match  = (stage_i.id_rs1 == stage_i.wb_rd) && |stage_i.id_rs1;
  assign id_wb_rs2_match  = (stage_i.id_rs2 == stage_i.wb_rd) && |stage_i.id_rs2;
  assign id_ex_rs1_match  = (stage_i.id_rs1 == stage_i.ex_rd) && |stage_i.id_rs1;
  assign id_ex_rs2_match  = (stage_i.id_rs2 == stage_i.ex_rd) && |stage_i.id_rs2;
  assign ex_mem_rs1_match = (stage_i.ex_rs1 == stage_i.mem_rd) && |stage_i.ex_rs1;
  assign ex_mem_rs2_match = (stage_i.ex_rs2 == stage_i.mem_rd) && |stage_i.ex_rs2;
  assign ex_wb_rs1_match  = (stage_i.ex_rs1 == stage_i.wb_rd) && |stage_i.ex_rs1;
  assign ex_wb_rs2_match  = (stage_i.ex_rs2 == stage_i.wb_rd) && |stage_i.ex_rs2;

  // ==========================================================
  // stalls
  // ==========================================================
  // load in EX feeding the instruction in ID, hold ID one cycle
  assign load_use_stall = stage_i.ex_mem_read && (id_ex_rs1_match || id_ex_rs2_match);

  // load in MEM still waiting for its response
  assign mem_req_stall = mem_req_i && !mem_done_i;

  // chain runs backward from MEM/WB
  assign mem_wb_stall = mem_req_stall;
  assign ex_mem_stall = mem_req_stall || mem_wb_stall;
  assign id_ex_stall  = ex_mem_stall;
  assign if_id_stall  = load_use_stall || id_ex_stall;

  // ==========================================================
  // forwarding
  // ==========================================================
  // MEM is younger than WB so it takes priority
  always_comb begin
    if (ex_mem_rs1_match && stage_i.mem_rd_write) begin
      ex_fwd_a = FORWARD_SEL_MEM_RESULT;
    end else if (ex_wb_rs1_match && stage_i.wb_rd_write) begin
      ex_fwd_a = FORWARD_SEL_WB_RESULT;
    end else begin
      ex_fwd_a = NO_FORWARD_SEL;
    end

    if (ex_mem_rs2_match && stage_i.mem_rd_write) begin
      ex_fwd_b = FORWARD_SEL_MEM_RESULT;
    end else if (ex_wb_rs2_match && stage_i.wb_rd_write) begin
      ex_fwd_b = FORWARD_SEL_WB_RESULT;
    end else begin
      ex_fwd_b = NO_FORWARD_SEL;
    end
  end

  // ID only sees WB, the regfile write lands at the end of the cycle
  assign ctrl_o.id_fwd_a = id_wb_rs1_match && stage_i.wb_rd_write;
  assign ctrl_o.id_fwd_b = id_wb_rs2_match && stage_i.wb_rd_write;
  assign ctrl_o.ex_fwd_a = ex_fwd_a;
  assign ctrl_o.ex_fwd_b = ex_fwd_b;

  // ==========================================================
  // flushes
  // ==========================================================
  assign mispredict_flush = stage_i.mem_mispredict;
  assign jump_flush       = stage_i.mem_jump_taken && !stage_i.mem_is_branch;
  assign any_trap         = stage_i.ex_trap || stage_i.mem_trap || stage_i.wb_trap;

  // predicted-taken flush only when the branch itself moves on,
  // otherwise the held branch would be lost
  assign ctrl_o.if_id_flush = mispredict_flush
                           || jump_flush
                           || (stage_i.id_predict_taken && !id_ex_stall && !if_id_stall)
                           || any_trap;

  assign ctrl_o.id_ex_flush = mispredict_flush
                           || jump_flush
                           || stage_i.mem_trap
                           || stage_i.wb_trap;

  // a stalled EX/MEM keeps its contents on redirect
  assign ctrl_o.ex_mem_flush = (mispredict_flush && !mem_wb_stall)
                            || (jump_flush && !mem_wb_stall)
                            || stage_i.mem_trap
                            || stage_i.wb_trap;

  // trap at commit kills whatever follows it in MEM
  assign ctrl_o.mem_wb_flush = stage_i.wb_trap;

  assign ctrl_o.if_id_stall  = if_id_stall;
  assign ctrl_o.id_ex_stall  = id_ex_stall;
  assign ctrl_o.ex_mem_stall = ex_mem_stall;
  assign ctrl_o.mem_wb_stall = mem_wb_stall;

endmodule

/* rtl/regfile.sv */
// register file: 32 x 32-bit, two asynchronous read ports, one synchronous write port
`timescale 1ns/1ps

module regfile (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [params_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
  input  logic [params_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
  output logic [params_pkg::XLEN-1:0]         rs1_data_o,
  output logic [params_pkg::XLEN-1:0]         rs2_data_o,
  input  logic                                we_i,
  input  logic [params_pkg::REG_ADDR_W-1:0]   wr_addr_i,
  input  logic [params_pkg::XLEN-1:0]         wr_data_i
);
  import params_pkg::*;

  logic [XLEN-1:0] regs_q [2**REG_ADDR_W];

  // x0 reads as zero whatever the array holds
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

  // no bypass, a same-cycle write is covered by the ID forward
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

/* rtl/load_port.sv */
// load port: credit counter and single-request sequencing for the load in MEM
`timescale 1ns/1ps

module load_port #(
  parameter int LOAD_CREDITS = 2
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        load_pending_i,
  input  logic [params_pkg::XLEN-1:0] addr_i,
  output params_pkg::mem_req_t        mem_req_o,
  input  params_pkg::mem_rsp_t        mem_rsp_i,
  input  logic                        credit_ret_i,
  output logic                        mem_busy_o,
  output logic                        mem_done_o,
  output logic [params_pkg::XLEN-1:0] load_data_o
);
  import params_pkg::*;

  localparam int CNT_W = $clog2(LOAD_CREDITS + 1);

  logic [CNT_W-1:0] credits_q;
  logic             issued_q;
  logic             req_fire;

  // one request per load, only with a credit in hand
  assign req_fire = load_pending_i && !issued_q && (credits_q != '0);

  assign mem_req_o.valid = req_fire;
  assign mem_req_o.addr  = addr_i;

  // responses are in order, so the first one after issue belongs to this load
  assign mem_busy_o  = load_pending_i;
  assign mem_done_o  = issued_q && mem_rsp_i.valid;
  assign load_data_o = mem_rsp_i.data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= CNT_W'(LOAD_CREDITS);
    end else begin
      credits_q <= credits_q - CNT_W'(req_fire) + CNT_W'(credit_ret_i);
    end
  end

  // issued flag covers the wait between request and response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issued_q <= 1'b0;
    end else if (mem_done_o) begin
      issued_q <= 1'b0;
    end else if (req_fire) begin
      issued_q <= 1'b1;
    end
  end

endmodule

/* rtl/pipe_datapath.sv */
// pipeline datapath: stage registers, forwarding muxes, adder, redirect and retire generation
`timescale 1ns/1ps

module pipe_datapath (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  params_pkg::inst_t                 inst_i,
  output logic                              inst_hold_o,
  input  params_pkg::hazard_ctrl_t          ctrl_i,
  output params_pkg::stage_info_t           stage_o,
  output logic [params_pkg::REG_ADDR_W-1:0] rf_rs1_addr_o,
  output logic [params_pkg::REG_ADDR_W-1:0] rf_rs2_addr_o,
  input  logic [params_pkg::XLEN-1:0]       rf_rs1_data_i,
  input  logic [params_pkg::XLEN-1:0]       rf_rs2_data_i,
  output logic                              rf_we_o,
  output logic [params_pkg::REG_ADDR_W-1:0] rf_wr_addr_o,
  output logic [params_pkg::XLEN-1:0]       rf_wr_data_o,
  output logic                              load_pending_o,
  output logic [params_pkg::XLEN-1:0]       load_addr_o,
  input  logic [params_pkg::XLEN-1:0]       load_data_i,
  output params_pkg::redirect_t             redirect_o,
  output params_pkg::retire_t               retire_o
);
  import params_pkg::*;

  typedef struct packed {
    inst_t           inst;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } ex_stage_t;

  typedef struct packed {
    inst_t           inst;
    logic [XLEN-1:0] result;
  } res_stage_t;

  inst_t           if_id_q;
  ex_stage_t       id_ex_q;
  res_stage_t      ex_mem_q;
  res_stage_t      mem_wb_q;
  logic [XLEN-1:0] id_a;
  logic [XLEN-1:0] id_b;
  logic [XLEN-1:0] ex_a;
  logic [XLEN-1:0] ex_b;
  logic [XLEN-1:0] ex_imm;
  logic [XLEN-1:0] ex_sum;
  logic [XLEN-1:0] mem_result;
  logic [XLEN-1:0] wb_result;
  logic            id_predict;
  logic            mem_live;
  logic            mem_branch;
  logic            mem_mispredict;
  logic            mem_jump;

  // only adds and loads write rd, a trapping instruction writes nothing
  function automatic logic writes_rd(inst_t i);
    return i.valid && !i.trap && ((i.kind == KIND_ALU) || (i.kind == KIND_LOAD));
  endfunction

  function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_t sel, logic [XLEN-1:0] own,
                                              logic [XLEN-1:0] mem_v, logic [XLEN-1:0] wb_v);
    case (sel)
      FORWARD_SEL_MEM_RESULT: return mem_v;
      FORWARD_SEL_WB_RESULT:  return wb_v;
      default:                return own;
    endcase
  endfunction

  // ==========================================================
  // IF/ID and decode
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (reset_i || ctrl_i.if_id_flush) begin
      if_id_q.valid <= 1'b0;
    end else if (!ctrl_i.if_id_stall) begin
      if_id_q <= inst_i;
    end
  end

  assign rf_rs1_addr_o = if_id_q.rs1;
  assign rf_rs2_addr_o = if_id_q.rs2;
  assign id_a = ctrl_i.id_fwd_a ? wb_result : rf_rs1_data_i;
  assign id_b = ctrl_i.id_fwd_b ? wb_result : rf_rs2_data_i;
  assign id_predict = if_id_q.valid && !if_id_q.trap && (if_id_q.kind == KIND_BRANCH)
                   && if_id_q.predict_taken;

  // ==========================================================
  // ID/EX and execute
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (reset_i || ctrl_i.id_ex_flush) begin
      id_ex_q.inst.valid <= 1'b0;
    end else if (ctrl_i.id_ex_stall) begin
      // held operands pick up forwards before the producer leaves WB
      id_ex_q.op_a <= ex_a;
      id_ex_q.op_b <= ex_b;
    end else if (ctrl_i.if_id_stall) begin
      // ID held but EX moves on, so a bubble goes in
      id_ex_q.inst.valid <= 1'b0;
    end else begin
      id_ex_q.inst <= if_id_q;
      id_ex_q.op_a <= id_a;
      id_ex_q.op_b <= id_b;
    end
  end

  assign ex_a   = fwd_mux(ctrl_i.ex_fwd_a, id_ex_q.op_a, mem_result, wb_result);
  assign ex_b   = fwd_mux(ctrl_i.ex_fwd_b, id_ex_q.op_b, mem_result, wb_result);
  assign ex_imm = {{(XLEN-IMM_W){id_ex_q.inst.imm[IMM_W-1]}}, id_ex_q.inst.imm};

  // loads always add the offset to rs1
  assign ex_sum = ex_a + ((id_ex_q.inst.use_imm || (id_ex_q.inst.kind == KIND_LOAD))
                          ? ex_imm : ex_b);

  // ==========================================================
  // EX/MEM and memory
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (reset_i || ctrl_i.ex_mem_flush) begin
      ex_mem_q.inst.valid <= 1'b0;
    end else if (!ctrl_i.ex_mem_stall) begin
      ex_mem_q.inst   <= id_ex_q.inst;
      ex_mem_q.result <= ex_sum;
    end
  end

  assign mem_live       = ex_mem_q.inst.valid && !ex_mem_q.inst.trap;
  assign load_pending_o = mem_live && (ex_mem_q.inst.kind == KIND_LOAD);
  assign load_addr_o    = ex_mem_q.result;
  assign mem_result     = (ex_mem_q.inst.kind == KIND_LOAD) ? load_data_i : ex_mem_q.result;

  // branch outcome resolves here
  assign mem_branch     = mem_live && (ex_mem_q.inst.kind == KIND_BRANCH);
  assign mem_mispredict = mem_branch
                       && (ex_mem_q.inst.predict_taken != ex_mem_q.inst.actual_taken);
  assign mem_jump       = mem_live && (ex_mem_q.inst.kind == KIND_JUMP);

  // ==========================================================
  // MEM/WB and writeback
  // ==========================================================
  // a waiting load sends a bubble to WB so nothing retires twice
  always_ff @(posedge clk_i) begin
    if (reset_i || ctrl_i.mem_wb_flush || ctrl_i.mem_wb_stall) begin
      mem_wb_q.inst.valid <= 1'b0;
    end else begin
      mem_wb_q.inst   <= ex_mem_q.inst;
      mem_wb_q.result <= mem_result;
    end
  end

  assign wb_result    = mem_wb_q.result;
  assign rf_we_o      = writes_rd(mem_wb_q.inst);
  assign rf_wr_addr_o = mem_wb_q.inst.rd;
  assign rf_wr_data_o = wb_result;

  assign retire_o.valid     = mem_wb_q.inst.valid;
  assign retire_o.tag       = mem_wb_q.inst.tag;
  assign retire_o.trap      = mem_wb_q.inst.trap;
  assign retire_o.writes_rd = rf_we_o && (mem_wb_q.inst.rd != '0);
  assign retire_o.rd        = mem_wb_q.inst.rd;
  assign retire_o.wdata     = wb_result;

  // ==========================================================
  // redirect, oldest stage first
  // ==========================================================
  always_comb begin
    redirect_o = '0;
    if (stage_o.wb_trap) begin
      redirect_o.valid  = 1'b1;
      redirect_o.target = mem_wb_q.inst.target;
    end else if (mem_mispredict) begin
      // not-taken resumes at the next sequential tag
      redirect_o.valid  = 1'b1;
      redirect_o.target = ex_mem_q.inst.actual_taken ? ex_mem_q.inst.target
                                                     : ex_mem_q.inst.tag + TAG_W'(1);
    end else if (mem_jump) begin
      redirect_o.valid  = 1'b1;
      redirect_o.target = ex_mem_q.inst.target;
    end else if (id_predict && !ctrl_i.if_id_stall && !stage_o.ex_trap && !stage_o.mem_trap) begin
      redirect_o.valid  = 1'b1;
      redirect_o.target = if_id_q.target;
    end
  end

  // every redirect flushes IF/ID, so the source may move on
  assign inst_hold_o = ctrl_i.if_id_stall && !redirect_o.valid;

  // ==========================================================
  // stage status for the hazard unit
  // ==========================================================
  assign stage_o.id_rs1           = if_id_q.valid ? if_id_q.rs1 : '0;
  assign stage_o.id_rs2           = if_id_q.valid ? if_id_q.rs2 : '0;
  assign stage_o.ex_rs1           = id_ex_q.inst.rs1;
  assign stage_o.ex_rs2           = id_ex_q.inst.rs2;
  assign stage_o.ex_rd            = id_ex_q.inst.rd;
  assign stage_o.mem_rd           = ex_mem_q.inst.rd;
  assign stage_o.wb_rd            = mem_wb_q.inst.rd;
  assign stage_o.mem_rd_write     = writes_rd(ex_mem_q.inst);
  assign stage_o.wb_rd_write      = rf_we_o;
  assign stage_o.ex_mem_read      = id_ex_q.inst.valid && !id_ex_q.inst.trap
                                 && (id_ex_q.inst.kind == KIND_LOAD);
  assign stage_o.mem_is_branch    = mem_branch;
  assign stage_o.mem_jump_taken   = mem_jump || (mem_branch && ex_mem_q.inst.actual_taken);
  assign stage_o.mem_mispredict   = mem_mispredict;
  assign stage_o.id_predict_taken = id_predict;
  assign stage_o.ex_trap          = id_ex_q.inst.valid && id_ex_q.inst.trap;
  assign stage_o.mem_trap         = ex_mem_q.inst.valid && ex_mem_q.inst.trap;
  assign stage_o.wb_trap          = mem_wb_q.inst.valid && mem_wb_q.inst.trap;

endmodule

/* rtl/pipe_top.sv */
// pipeline top: datapath, hazard unit, register file and load port
`timescale 1ns/1ps

module pipe_top #(
  parameter int LOAD_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  params_pkg::inst_t     inst_i,
  output logic                  inst_hold_o,
  output params_pkg::redirect_t redirect_o,
  output params_pkg::mem_req_t  mem_req_o,
  input  params_pkg::mem_rsp_t  mem_rsp_i,
  input  logic                  credit_ret_i,
  output params_pkg::retire_t   retire_o
);
  import params_pkg::*;

  hazard_ctrl_t          ctrl;
  stage_info_t           stage;
  logic [REG_ADDR_W-1:0] rf_rs1_addr;
  logic [REG_ADDR_W-1:0] rf_rs2_addr;
  logic [XLEN-1:0]       rf_rs1_data;
  logic [XLEN-1:0]       rf_rs2_data;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_wr_addr;
  logic [XLEN-1:0]       rf_wr_data;
  logic                  load_pending;
  logic [XLEN-1:0]       load_addr;
  logic [XLEN-1:0]       load_data;
  logic                  mem_busy;
  logic                  mem_done;

  pipe_datapath u_datapath (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_i         (inst_i),
    .inst_hold_o    (inst_hold_o),
    .ctrl_i         (ctrl),
    .stage_o        (stage),
    .rf_rs1_addr_o  (rf_rs1_addr),
    .rf_rs2_addr_o  (rf_rs2_addr),
    .rf_rs1_data_i  (rf_rs1_data),
    .rf_rs2_data_i  (rf_rs2_data),
    .rf_we_o        (rf_we),
    .rf_wr_addr_o   (rf_wr_addr),
    .rf_wr_data_o   (rf_wr_data),
    .load_pending_o (load_pending),
    .load_addr_o    (load_addr),
    .load_data_i    (load_data),
    .redirect_o     (redirect_o),
    .retire_o       (retire_o)
  );

  hazard_unit u_hazard (
    .stage_i    (stage),
    .mem_req_i  (mem_busy),
    .mem_done_i (mem_done),
    .ctrl_o     (ctrl)
  );

  regfile u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rf_rs1_addr),
    .rs2_addr_i (rf_rs2_addr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .we_i       (rf_we),
    .wr_addr_i  (rf_wr_addr),
    .wr_data_i  (rf_wr_data)
  );

  load_port #(
    .LOAD_CREDITS (LOAD_CREDITS)
  ) u_load_port (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .load_pending_i (load_pending),
    .addr_i         (load_addr),
    .mem_req_o      (mem_req_o),
    .mem_rsp_i      (mem_rsp_i),
    .credit_ret_i   (credit_ret_i),
    .mem_busy_o     (mem_busy),
    .mem_done_o     (mem_done),
    .load_data_o    (load_data)
  );

endmodule

/* tb/pipe_top_assertions.sv */
// protocol assertions for pipe_top: credit rule, single-cycle requests, held instruction, quiet reset
`timescale 1ns/1ps

module pipe_top_assertions #(
  parameter int LOAD_CREDITS = 2
) (
  input logic                 clk_i,
  input logic                 reset_i,
  input params_pkg::inst_t    inst_i,
  input logic                 inst_hold_o,
  input params_pkg::mem_req_t mem_req_o,
  input logic                 credit_ret_i,
  input params_pkg::retire_t  retire_o
);

  int credits;

  // credit count as seen on the memory port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits <= LOAD_CREDITS;
    end else begin
      credits <= credits - int'(mem_req_o.valid) + int'(credit_ret_i);
    end
  end

  request_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o.valid |-> (credits > 0))
    else $error("memory request issued with no credit left");

  // one request per load, so never two in a row
  request_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o.valid |=> !mem_req_o.valid)
    else $error("memory request held longer than one cycle");

  held_inst_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    inst_hold_o |=> $stable(inst_i))
    else $error("instruction changed while the pipeline held it");

  quiet_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> (!retire_o.valid && !mem_req_o.valid))
    else $error("retire or memory request active during reset");

endmodule

bind pipe_top pipe_top_assertions #(
  .LOAD_CREDITS (LOAD_CREDITS)
) u_assertions (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .inst_i       (inst_i),
  .inst_hold_o  (inst_hold_o),
  .mem_req_o    (mem_req_o),
  .credit_ret_i (credit_ret_i),
  .retire_o     (retire_o)
);

/* tb/pipe_top_tb.sv */
// testbench with clock, reset, random program, source, memory responder, reference model, checker
`timescale 1ns/1ps

module pipe_top_tb;
  import params_pkg::*;

  localparam int PROG_LEN       = 200;
  // a single credit makes a load wait for the credit of the load before it
  localparam int LOAD_CREDITS   = 1;
  localparam int SEED           = 86629;
  localparam int TIMEOUT_CYCLES = 20 * PROG_LEN;
  localparam int DRAIN_CYCLES   = 20;
  localparam int NUM_DELAYS     = 64;

  logic      clk;
  logic      reset;
  inst_t     inst;
  logic      inst_hold;
  redirect_t redirect;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp;
  logic      credit_ret;
  retire_t   retire;

  inst_t           prog [PROG_LEN];
  retire_t         exp_q [$];
  logic [XLEN-1:0] req_q [$];
  int unsigned     delay_tab [NUM_DELAYS];
  int              cycle_cnt;

  pipe_top #(
    .LOAD_CREDITS (LOAD_CREDITS)
  ) DUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .inst_i       (inst),
    .inst_hold_o  (inst_hold),
    .redirect_o   (redirect),
    .mem_req_o    (mem_req),
    .mem_rsp_i    (mem_rsp),
    .credit_ret_i (credit_ret),
    .retire_o     (retire)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ==========================================================
  // program and reference model
  // ==========================================================
  function automatic logic [XLEN-1:0] sext_imm(logic [IMM_W-1:0] imm);
    return {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

  // memory contents follow the address
  function automatic logic [XLEN-1:0] mem_word(logic [XLEN-1:0] addr);
    return addr * 32'd3 + 32'd7;
  endfunction

  function automatic inst_t fetch_inst(int pc);
    if (pc < PROG_LEN) begin
      return prog[pc];
    end
    return '0;
  endfunction

  // x0..x7 only so neighbours depend on each other often
  function automatic void build_program();
    int unsigned roll;
    int          span;
    for (int t = 0; t < PROG_LEN; t++) begin
      roll                  = $urandom % 100;
      prog[t]               = '0;
      prog[t].valid         = 1'b1;
      prog[t].tag           = TAG_W'(t);
      prog[t].rd            = REG_ADDR_W'($urandom % 8);
      prog[t].rs1           = REG_ADDR_W'($urandom % 8);
      prog[t].rs2           = REG_ADDR_W'($urandom % 8);
      prog[t].imm           = IMM_W'($urandom);
      prog[t].use_imm       = 1'($urandom % 2);
      prog[t].predict_taken = 1'($urandom % 2);
      prog[t].actual_taken  = 1'($urandom % 2);
      prog[t].trap          = (($urandom % 100) < 3);
      if (roll < 30) begin
        prog[t].kind = KIND_LOAD;
      end else if (roll < 70) begin
        prog[t].kind = KIND_ALU;
      end else if (roll < 90) begin
        prog[t].kind = KIND_BRANCH;
      end else begin
        prog[t].kind = KIND_JUMP;
      end
      // targets only point forward and the end tag means stop
      span = t + 1 + int'($urandom % 6);
      if (span > PROG_LEN) begin
        span = PROG_LEN;
      end
      prog[t].target = TAG_W'(span);
    end
  endfunction

  // in-order execution along the actual path with one record per committed instruction
  function automatic void run_reference();
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] value;
    retire_t         rec;
    inst_t           ins;
    int              pc;
    int              next_pc;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = 0;
    while (pc < PROG_LEN) begin
      ins       = prog[pc];
      rec       = '0;
      rec.valid = 1'b1;
      rec.tag   = ins.tag;
      rec.trap  = ins.trap;
      rec.rd    = ins.rd;
      next_pc   = pc + 1;
      if (ins.trap) begin
        // handler tag and no register write
        next_pc = int'(ins.target);
      end else if (ins.kind == KIND_ALU || ins.kind == KIND_LOAD) begin
        if (ins.kind == KIND_LOAD) begin
          value = mem_word(regs[ins.rs1] + sext_imm(ins.imm));
        end else begin
          value = regs[ins.rs1] + (ins.use_imm ? sext_imm(ins.imm) : regs[ins.rs2]);
        end
        if (ins.rd != '0) begin
          regs[ins.rd]  = value;
          rec.writes_rd = 1'b1;
          rec.wdata     = value;
        end
      end else if (ins.kind == KIND_JUMP || ins.actual_taken) begin
        next_pc = int'(ins.target);
      end
      exp_q.push_back(rec);
      pc = next_pc;
    end
  endfunction

  // ==========================================================
  // checking
  // ==========================================================
  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(string field, logic [XLEN-1:0] exp_v, logic [XLEN-1:0] act_v);
    assert (exp_v === act_v)
      else begin
        $display("ERROR at %0d ns: %s expected %0h actual %0h", $time, field, exp_v, act_v);
        abort_run();
      end
  endtask

  // rd and wdata only mean something when the register is written
  task automatic check_retire(retire_t exp_r, retire_t act_r);
    check_value("retire_o.tag", XLEN'(exp_r.tag), XLEN'(act_r.tag));
    check_value("retire_o.trap", XLEN'(exp_r.trap), XLEN'(act_r.trap));
    check_value("retire_o.writes_rd", XLEN'(exp_r.writes_rd), XLEN'(act_r.writes_rd));
    if (exp_r.writes_rd) begin
      check_value("retire_o.rd", XLEN'(exp_r.rd), XLEN'(act_r.rd));
      check_value("retire_o.wdata", exp_r.wdata, act_r.wdata);
    end
  endtask

  // ==========================================================
  // stimulus
  // ==========================================================
  // instruction source that follows redirects and holds while the pipeline stalls
  initial begin : source
    int        pc;
    redirect_t redir;
    logic      hold;
    reset = 1'b1;
    inst  = '0;
    void'($urandom(SEED));
    build_program();
    run_reference();
    for (int i = 0; i < NUM_DELAYS; i++) begin
      delay_tab[i] = $urandom % 5;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    pc    = 0;
    inst  = fetch_inst(pc);
    forever begin
      @(negedge clk);
      redir = redirect;
      hold  = inst_hold;
      @(posedge clk);
      #1;
      if (redir.valid) begin
        pc = int'(redir.target);
      end else if (!hold && pc < PROG_LEN) begin
        pc++;
      end
      inst = fetch_inst(pc);
    end
  end

  // requests last one cycle and are picked up mid-cycle
  always @(negedge clk) begin
    if (!reset && mem_req.valid) begin
      req_q.push_back(mem_req.addr);
    end
  end

  // in-order memory with a response after 0..4 idle cycles and the credit back one cycle later
  initial begin : responder
    logic [XLEN-1:0] addr;
    int              n_rsp;
    mem_rsp    = '0;
    credit_ret = 1'b0;
    n_rsp      = 0;
    forever begin
      @(posedge clk);
      if (req_q.size() != 0) begin
        addr = req_q.pop_front();
        repeat (delay_tab[n_rsp % NUM_DELAYS]) @(posedge clk);
        n_rsp++;
        #1;
        mem_rsp.valid = 1'b1;
        mem_rsp.data  = mem_word(addr);
        @(posedge clk);
        #1;
        mem_rsp.valid = 1'b0;
        credit_ret    = 1'b1;
        @(posedge clk);
        #1;
        credit_ret = 1'b0;
      end
    end
  end

  // ==========================================================
  // comparison and end of run
  // ==========================================================
  initial begin : compare
    retire_t exp_r;
    int      extra;
    extra = 0;
    @(negedge reset);
    while (exp_q.size() != 0) begin
      @(negedge clk);
      if (retire.valid) begin
        exp_r = exp_q.pop_front();
        check_retire(exp_r, retire);
      end
    end
    // nothing may retire past the end of the program
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (retire.valid) begin
        extra++;
      end
    end
    if (extra == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d instructions retired after the last expected record", extra);
      abort_run();
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d records never retired", cycle_cnt, exp_q.size());
    abort_run();
  end

endmodule

/* pipe_top.f */
rtl/params_pkg.sv
rtl/hazard_unit.sv
rtl/regfile.sv
rtl/load_port.sv
rtl/pipe_datapath.sv
rtl/pipe_top.sv
tb/pipe_top_assertions.sv
tb/pipe_top_tb.sv

/* Makefile */
# Verilator build and run of the pipeline testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pipe_top_tb -f pipe_top.f
	./obj_dir/Vpipe_top_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
